// ==== src/lc4_pkg.sv ====
// ================================================
// lc4 shared definitions: widths, opcodes, reset pc,
// control and pipeline records for the core
// ================================================

package lc4_pkg;

    // datapath and register file sizes
    localparam int WORD_W    = 16;
    localparam int REG_SEL_W = 3;
    localparam int NUM_REGS  = 8;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [REG_SEL_W-1:0] reg_sel_t;
    // ordered n, z, p from msb to lsb
    typedef logic [2:0]           nzp_t;

    // first fetch address after reset
    localparam word_t RESET_PC = 16'h8200;

    // major opcodes, insn[15:12]
    localparam logic [3:0] OP_BR    = 4'b0000;
    localparam logic [3:0] OP_ADD   = 4'b0001;
    localparam logic [3:0] OP_AND   = 4'b0101;
    localparam logic [3:0] OP_LDR   = 4'b0110;
    localparam logic [3:0] OP_STR   = 4'b0111;
    localparam logic [3:0] OP_CONST = 4'b1001;

    // none is zero so a cleared record means no operation
    typedef enum logic [3:0] {
        ALU_NONE, ALU_ADD, ALU_SUB, ALU_AND, ALU_ADDI,
        ALU_ANDI, ALU_CONST, ALU_ADDR, ALU_BR
    } alu_op_e;

    // bypass sources for an operand
    typedef enum logic [1:0] {FWD_RF, FWD_MEM, FWD_WB} fwd_sel_e;

    typedef struct packed {
        reg_sel_t rs;
        reg_sel_t rt;
        reg_sel_t wsel;
        logic     rs_re;
        logic     rt_re;
        logic     regfile_we;
        logic     nzp_we;
        logic     is_load;
        logic     is_store;
        logic     is_branch;
        alu_op_e  alu_op;
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t insn;
        ctrl_t ctrl;
    } stage_t;

    typedef struct packed {
        word_t    pc;
        word_t    insn;
        logic     regfile_we;
        reg_sel_t wsel;
        word_t    wdata;
        logic     nzp_we;
        nzp_t     nzp;
        logic     dmem_we;
        word_t    dmem_addr;
        word_t    dmem_data;
    } retire_t;

    // sign of a word as nzp bits
    function automatic nzp_t nzp_of(input word_t value);
        if (value == '0) begin
            return 3'b010;
        end
        return value[WORD_W-1] ? 3'b100 : 3'b001;
    endfunction

endpackage

// ==== src/lc4_pc_counter.sv ====
// ================================================
// program counter: holds on stall, loads a branch
// target on redirect, otherwise counts up by one
// ================================================
`timescale 1ns/100ps

module lc4_pc_counter
    import lc4_pkg::*;
(
    input  logic  gwe,
    input  logic  i_arst_n,
    input  logic  i_stall,
    input  logic  i_redirect,
    input  word_t i_target,
    output word_t o_pc
);

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_pc <= RESET_PC;
        end else if (i_redirect) begin
            // taken branch resolved in execute
            o_pc <= i_target;
        end else if (!i_stall) begin
            o_pc <= o_pc + 16'd1;
        end
    end

    // a stall needs a load in execute, a redirect needs a branch there
    assert property (@(posedge gwe) disable iff (!i_arst_n)
        !(i_stall && i_redirect));

endmodule

// ==== src/lc4_decoder.sv ====
// ================================================
// lc4 decoder: one instruction word to control bits
// ================================================
`timescale 1ns/100ps

module lc4_decoder
    import lc4_pkg::*;
(
    input  word_t i_insn,
    output ctrl_t o_ctrl
);

    always_comb begin
        o_ctrl = '0;
        // field positions shared by the kept formats
        o_ctrl.rs     = i_insn[8:6];
        o_ctrl.rt     = i_insn[2:0];
        o_ctrl.wsel   = i_insn[11:9];
        o_ctrl.alu_op = ALU_NONE;
        case (i_insn[15:12])
            OP_BR: begin
                // nzp mask in [11:9], all zero never taken
                o_ctrl.is_branch = 1'b1;
                o_ctrl.alu_op    = ALU_BR;
            end
            OP_ADD, OP_AND: begin
                if (i_insn[5]) begin
                    // immediate form, imm5 in [4:0]
                    o_ctrl.rs_re      = 1'b1;
                    o_ctrl.regfile_we = 1'b1;
                    o_ctrl.nzp_we     = 1'b1;
                    o_ctrl.alu_op     = (i_insn[15:12] == OP_ADD) ? ALU_ADDI : ALU_ANDI;
                end else if (i_insn[5:3] == 3'b000 || 
                             (i_insn[15:12] == OP_ADD && i_insn[5:3] == 3'b010)) begin
                    o_ctrl.rs_re      = 1'b1;
                    o_ctrl.rt_re      = 1'b1;
                    o_ctrl.regfile_we = 1'b1;
                    o_ctrl.nzp_we     = 1'b1;
                    if (i_insn[15:12] == OP_AND) begin
                        o_ctrl.alu_op = ALU_AND;
                    end else begin
                        o_ctrl.alu_op = i_insn[4] ? ALU_SUB : ALU_ADD;
                    end
                end
            end
            OP_LDR: begin
                o_ctrl.rs_re      = 1'b1;
                o_ctrl.regfile_we = 1'b1;
                o_ctrl.nzp_we     = 1'b1;
                o_ctrl.is_load    = 1'b1;
                o_ctrl.alu_op     = ALU_ADDR;
            end
            OP_STR: begin
                // store data register sits in the rd field
                o_ctrl.rt       = i_insn[11:9];
                o_ctrl.rs_re    = 1'b1;
                o_ctrl.rt_re    = 1'b1;
                o_ctrl.is_store = 1'b1;
                o_ctrl.alu_op   = ALU_ADDR;
            end
            OP_CONST: begin
                o_ctrl.regfile_we = 1'b1;
                o_ctrl.nzp_we     = 1'b1;
                o_ctrl.alu_op     = ALU_CONST;
            end
            // everything else stays a no-op
            default: ;
        endcase
    end

endmodule

// ==== src/lc4_regfile.sv ====
// ================================================
// eight-entry register file, two reads, one write,
// new data visible on a same-cycle read
// ================================================
`timescale 1ns/100ps

module lc4_regfile
    import lc4_pkg::*;
(
    input  logic     gwe,
    input  logic     i_arst_n,
    input  reg_sel_t i_rs,
    input  reg_sel_t i_rt,
    input  reg_sel_t i_rd,
    input  word_t    i_wdata,
    input  logic     i_we,
    output word_t    o_rs_data,
    output word_t    o_rt_data
);

    word_t regs [NUM_REGS];

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we) begin
            regs[i_rd] <= i_wdata;
        end
    end

    // write-through covers the writeback to decode distance
    assign o_rs_data = (i_we && i_rd == i_rs) ? i_wdata : regs[i_rs];
    assign o_rt_data = (i_we && i_rd == i_rt) ? i_wdata : regs[i_rt];

endmodule

// ==== src/lc4_alu.sv ====
// ================================================
// lc4 alu: register and immediate ops, const,
// memory address and branch target
// ================================================
`timescale 1ns/100ps

module lc4_alu
    import lc4_pkg::*;
(
    input  alu_op_e i_op,
    input  word_t   i_insn,
    input  word_t   i_pc,
    input  word_t   i_rs_data,
    input  word_t   i_rt_data,
    output word_t   o_result
);

    word_t imm5_sx;
    word_t imm6_sx;
    word_t imm9_sx;

    // sign-extended immediate fields
    assign imm5_sx = {{11{i_insn[4]}}, i_insn[4:0]};
    assign imm6_sx = {{10{i_insn[5]}}, i_insn[5:0]};
    assign imm9_sx = {{7{i_insn[8]}}, i_insn[8:0]};

    always_comb begin
        case (i_op)
            ALU_ADD:   o_result = i_rs_data + i_rt_data;
            ALU_SUB:   o_result = i_rs_data - i_rt_data;
            ALU_AND:   o_result = i_rs_data & i_rt_data;
            ALU_ADDI:  o_result = i_rs_data + imm5_sx;
            ALU_ANDI:  o_result = i_rs_data & imm5_sx;
            ALU_CONST: o_result = imm9_sx;
            // base plus offset for ldr and str
            ALU_ADDR:  o_result = i_rs_data + imm6_sx;
            // target relative to the next pc
            ALU_BR:    o_result = i_pc + 16'd1 + imm9_sx;
            default:   o_result = '0;
        endcase
    end

endmodule

// ==== src/lc4_hazard_unit.sv ====
// ================================================
// hazard unit: load-use and load-branch stalls,
// bypass selects for execute and memory operands
// ================================================
`timescale 1ns/100ps

module lc4_hazard_unit
    import lc4_pkg::*;
(
    input  stage_t   i_dec,
    input  stage_t   i_exe,
    input  stage_t   i_mem,
    input  stage_t   i_wb,
    output logic     o_stall,
    output fwd_sel_e o_rs_fwd,
    output fwd_sel_e o_rt_fwd,
    output fwd_sel_e o_st_fwd
);

    logic exe_load;
    logic dec_needs_load;

    // youngest valid writer of a register wins
    function automatic fwd_sel_e pick_src(input logic re, input reg_sel_t sel);
        if (re && i_mem.valid && i_mem.ctrl.regfile_we && i_mem.ctrl.wsel == sel) begin
            return FWD_MEM;
        end
        if (re && i_wb.valid && i_wb.ctrl.regfile_we && i_wb.ctrl.wsel == sel) begin
            return FWD_WB;
        end
        return FWD_RF;
    endfunction

    assign exe_load = i_exe.valid && i_exe.ctrl.is_load;

    // store data is skipped here, it is patched in memory
    // a branch waits so it sees the load's nzp
    assign dec_needs_load =
        (i_dec.ctrl.rs_re && i_dec.ctrl.rs == i_exe.ctrl.wsel) ||
        (i_dec.ctrl.rt_re && !i_dec.ctrl.is_store && i_dec.ctrl.rt == i_exe.ctrl.wsel) ||
        i_dec.ctrl.is_branch;

    assign o_stall = exe_load && i_dec.valid && dec_needs_load;

    always_comb begin
        o_rs_fwd = pick_src(i_exe.ctrl.rs_re, i_exe.ctrl.rs);
        o_rt_fwd = pick_src(i_exe.ctrl.rt_re, i_exe.ctrl.rt);
        // wm bypass for the store value
        o_st_fwd = FWD_RF;
        if (i_mem.valid && i_mem.ctrl.is_store && i_wb.valid &&
            i_wb.ctrl.regfile_we && i_wb.ctrl.wsel == i_mem.ctrl.rt) begin
            o_st_fwd = FWD_WB;
        end
    end

    // never hold decode behind a branch that may redirect
    always_comb begin
        assert #0 (!(o_stall && i_exe.valid && i_exe.ctrl.is_branch));
    end

endmodule

// ==== src/lc4_core.sv ====
// ================================================
// lc4 core: five-stage scalar pipeline with bypass,
// load stalls, nzp register and a retire trace
// ================================================
`timescale 1ns/100ps

module lc4_core
    import lc4_pkg::*;
(
    input  logic    gwe,
    input  logic    i_arst_n,
    input  word_t   i_insn,
    input  word_t   i_dmem_rdata,
    output word_t   o_pc,
    output word_t   o_dmem_addr,
    output word_t   o_dmem_wdata,
    output logic    o_dmem_we,
    output retire_t o_retire,
    output logic    o_retire_valid
);

    stage_t   dec_q, dec_s, exe_q, mem_q, wb_q;
    ctrl_t    dec_ctrl;
    word_t    rf_rs_data, rf_rt_data, exe_rs_q, exe_rt_q;
    word_t    rs_val, rt_val, alu_res;
    word_t    mem_res_q, mem_st_q, st_data;
    word_t    wb_res_q, wb_mem_q, wb_value;
    logic     stall, redirect, mem_is_load, mem_is_access;
    fwd_sel_e rs_fwd, rt_fwd, st_fwd;
    nzp_t     nzp_q, ld_nzp;

    lc4_pc_counter u_pc (
        .gwe(gwe), .i_arst_n(i_arst_n), .i_stall(stall),
        .i_redirect(redirect), .i_target(alu_res), .o_pc(o_pc)
    );

    lc4_hazard_unit u_hazard (
        .i_dec(dec_s), .i_exe(exe_q), .i_mem(mem_q), .i_wb(wb_q),
        .o_stall(stall), .o_rs_fwd(rs_fwd), .o_rt_fwd(rt_fwd), .o_st_fwd(st_fwd)
    );

    // decode register, squashed on redirect and held on stall
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            dec_q <= '0;
        end else if (redirect) begin
            dec_q <= '0;
        end else if (!stall) begin
            dec_q.valid <= 1'b1;
            dec_q.pc    <= o_pc;
            dec_q.insn  <= i_insn;
            dec_q.ctrl  <= '0;
        end
    end

    lc4_decoder u_dec (.i_insn(dec_q.insn), .o_ctrl(dec_ctrl));

    // a bubble in decode carries no enables
    always_comb begin
        dec_s      = dec_q;
        dec_s.ctrl = dec_q.valid ? dec_ctrl : '0;
    end

    lc4_regfile u_rf (
        .gwe(gwe), .i_arst_n(i_arst_n), .i_rs(dec_s.ctrl.rs), .i_rt(dec_s.ctrl.rt),
        .i_rd(wb_q.ctrl.wsel), .i_wdata(wb_value), .i_we(wb_q.valid && wb_q.ctrl.regfile_we),
        .o_rs_data(rf_rs_data), .o_rt_data(rf_rt_data)
    );

    // control registers for execute, memory and writeback
    // execute takes a bubble on stall or on a taken branch
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            exe_q <= '0;
            mem_q <= '0;
            wb_q  <= '0;
        end else begin
            exe_q <= (stall || redirect) ? '0 : dec_s;
            mem_q <= exe_q;
            wb_q  <= mem_q;
        end
    end

    // operand and result registers
    always_ff @(posedge gwe) begin
        exe_rs_q  <= rf_rs_data;
        exe_rt_q  <= rf_rt_data;
        mem_res_q <= alu_res;
        mem_st_q  <= rt_val;
        wb_res_q  <= mem_res_q;
        // loaded word, or the store value for the trace
        wb_mem_q  <= mem_q.ctrl.is_store ? st_data : i_dmem_rdata;
    end

    // mx and wx bypass muxes
    always_comb begin
        case (rs_fwd)
            FWD_MEM: rs_val = mem_res_q;
            FWD_WB:  rs_val = wb_value;
            default: rs_val = exe_rs_q;
        endcase
        case (rt_fwd)
            FWD_MEM: rt_val = mem_res_q;
            FWD_WB:  rt_val = wb_value;
            default: rt_val = exe_rt_q;
        endcase
    end

    lc4_alu u_alu (
        .i_op(exe_q.ctrl.alu_op), .i_insn(exe_q.insn), .i_pc(exe_q.pc),
        .i_rs_data(rs_val), .i_rt_data(rt_val), .o_result(alu_res)
    );

    assign mem_is_load = mem_q.valid && mem_q.ctrl.is_load;
    assign ld_nzp      = nzp_of(i_dmem_rdata);
    // the load-branch stall lets a load set nzp before its branch reaches execute
    assign redirect    = exe_q.valid && exe_q.ctrl.is_branch &&
                         ((nzp_q & exe_q.insn[11:9]) != '0);

    // alu writers in execute are younger than a load in memory
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            nzp_q <= '0;
        end else if (exe_q.valid && exe_q.ctrl.nzp_we && !exe_q.ctrl.is_load) begin
            nzp_q <= nzp_of(alu_res);
        end else if (mem_is_load) begin
            nzp_q <= ld_nzp;
        end
    end

    // data memory port
    assign mem_is_access = mem_q.valid && (mem_q.ctrl.is_load || mem_q.ctrl.is_store);
    assign st_data       = (st_fwd == FWD_WB) ? wb_value : mem_st_q;
    assign o_dmem_we     = mem_q.valid && mem_q.ctrl.is_store;
    assign o_dmem_addr   = mem_is_access ? mem_res_q : '0;
    assign o_dmem_wdata  = o_dmem_we ? st_data : '0;

    // writeback value and retire trace
    assign wb_value       = wb_q.ctrl.is_load ? wb_mem_q : wb_res_q;
    assign o_retire_valid = wb_q.valid;

    always_comb begin
        o_retire            = '0;
        o_retire.pc         = wb_q.pc;
        o_retire.insn       = wb_q.insn;
        o_retire.regfile_we = wb_q.ctrl.regfile_we;
        o_retire.wsel       = wb_q.ctrl.wsel;
        o_retire.nzp_we     = wb_q.ctrl.nzp_we;
        o_retire.dmem_we    = wb_q.ctrl.is_store;
        if (wb_q.ctrl.regfile_we) begin
            o_retire.wdata = wb_value;
        end
        if (wb_q.ctrl.nzp_we) begin
            o_retire.nzp = nzp_of(wb_value);
        end
        if (wb_q.ctrl.is_load || wb_q.ctrl.is_store) begin
            o_retire.dmem_addr = wb_res_q;
            o_retire.dmem_data = wb_mem_q;
        end
    end

    // a write on the port only ever comes from a store opcode in memory
    assert property (@(posedge gwe) disable iff (!i_arst_n)
        o_dmem_we |-> (mem_q.valid && mem_q.insn[15:12] == OP_STR));

endmodule

// ==== verif/tb_lc4_core.sv ====
// ================================================
// lc4 core testbench: random programs run against
// an isa model, retire trace compared per field
// ================================================
`timescale 1ns/100ps

module tb_lc4_core
    import lc4_pkg::*;
();

    localparam int       PROG_LEN       = 40;
    localparam int       PROG_SLOTS     = 256;
    localparam int       NUM_PROGS      = 5;
    localparam int       RETIRE_TIMEOUT = 20;
    localparam reg_sel_t BASE_REG       = 3'd6;
    localparam word_t    END_PC         = RESET_PC + PROG_LEN;

    logic    gwe;
    logic    arst_n;
    word_t   insn;
    word_t   dmem_rdata;
    word_t   pc;
    word_t   dmem_addr;
    word_t   dmem_wdata;
    logic    dmem_we;
    retire_t retire;
    logic    retire_valid;

    word_t       imem [PROG_SLOTS];
    word_t       dmem [65536];
    word_t       mdl_mem [65536];
    word_t       mdl_regs [NUM_REGS];
    nzp_t        mdl_nzp;
    logic [31:0] lfsr_q;
    word_t       fetch_idx;
    word_t       port_addr_q;
    word_t       port_wdata_q;
    logic        port_we_q;

    lc4_core dut_i (
        .gwe(gwe), .i_arst_n(arst_n), .i_insn(insn), .i_dmem_rdata(dmem_rdata),
        .o_pc(pc), .o_dmem_addr(dmem_addr), .o_dmem_wdata(dmem_wdata),
        .o_dmem_we(dmem_we), .o_retire(retire), .o_retire_valid(retire_valid)
    );

    initial begin
        gwe = 1'b0;
        forever begin
            #10 gwe = ~gwe;
        end
    end

    // instruction memory answers in the same cycle, zero words past the program
    assign fetch_idx  = pc - RESET_PC;
    assign insn       = (fetch_idx < PROG_SLOTS) ? imem[fetch_idx[7:0]] : '0;
    assign dmem_rdata = dmem[dmem_addr];

    // store lands at the edge closing its memory cycle
    always @(posedge gwe) begin
        // port values of the instruction now entering writeback
        port_addr_q  <= dmem_addr;
        port_wdata_q <= dmem_wdata;
        port_we_q    <= dmem_we;
        if (dmem_we) begin
            dmem[dmem_addr] <= dmem_wdata;
        end
    end

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit taken
    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v      = {v[14:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return v;
    endfunction

    // sign-extend the low field of an instruction
    function automatic word_t sext(input word_t v, input int bits);
        word_t m;
        m = 16'hFFFF << bits;
        return v[bits-1] ? (v | m) : (v & ~m);
    endfunction

    function automatic nzp_t sign_bits(input word_t v);
        if (v == 16'h0000) begin
            return 3'b010;
        end
        return v[15] ? 3'b100 : 3'b001;
    endfunction

    // initial data memory contents, mixes every address bit
    function automatic word_t fill_value(input int addr);
        word_t a;
        a = addr[15:0];
        return {a[7:0], a[15:8]} ^ (a * 16'd3) ^ 16'h5a3c;
    endfunction

    // registers biased to r0..r3, memory ops go through the base register
    function automatic word_t gen_insn(input int idx);
        logic [3:0] kind;
        reg_sel_t   rd;
        reg_sel_t   rs;
        reg_sel_t   rt;
        word_t      imm;
        logic [2:0] mask;
        int         off;
        kind = 4'(take_bits(4));
        rd   = 3'(take_bits(2));
        rs   = 3'(take_bits(2));
        rt   = 3'(take_bits(2));
        imm  = take_bits(9);
        mask = 3'(take_bits(3));
        off  = int'(take_bits(2));
        // forward branches stay inside the program or hit its end
        if (idx + 1 + off > PROG_LEN) begin
            off = PROG_LEN - idx - 1;
        end
        case (kind)
            4'd0, 4'd1:   return {OP_ADD, rd, rs, 3'b000, rt};
            4'd2:         return {OP_ADD, rd, rs, 3'b010, rt};
            4'd3:         return {OP_ADD, rd, rs, 1'b1, imm[4:0]};
            4'd4:         return {OP_AND, rd, rs, 3'b000, rt};
            4'd5:         return {OP_AND, rd, rs, 1'b1, imm[4:0]};
            4'd6, 4'd7:   return {OP_CONST, rd, imm[8:0]};
            4'd8, 4'd9:   return {OP_LDR, rd, BASE_REG, imm[5:0]};
            4'd10, 4'd11: return {OP_STR, rt, BASE_REG, imm[5:0]};
            default:      return {OP_BR, mask, 9'(off)};
        endcase
    endfunction

    task automatic build_program();
        // base 0x60 puts all accesses in 0x40..0x7f
        imem[0] = {OP_CONST, BASE_REG, 9'h060};
        for (int i = 1; i < PROG_SLOTS; i++) begin
            imem[i] = (i < PROG_LEN) ? gen_insn(i) : 16'h0000;
        end
        for (int a = 0; a < 65536; a++) begin
            dmem[a]    <= fill_value(a);
            mdl_mem[a]  = fill_value(a);
        end
        for (int r = 0; r < NUM_REGS; r++) begin
            mdl_regs[r] = '0;
        end
        mdl_nzp = '0;
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_equal(input string what, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH at %0t ns: %s is %h, expected %h",
                               $time, what, got, exp));
        end
    endtask

    task automatic write_reg(inout retire_t exp, input reg_sel_t rd, input word_t val);
        mdl_regs[rd]   = val;
        mdl_nzp        = sign_bits(val);
        exp.regfile_we = 1'b1;
        exp.wsel       = rd;
        exp.wdata      = val;
        exp.nzp_we     = 1'b1;
        exp.nzp        = mdl_nzp;
    endtask

    // executes one instruction in program order, gives its retire record
    task automatic model_step(inout word_t mpc, output retire_t exp);
        word_t w;
        word_t a;
        word_t b;
        word_t idx;
        idx      = mpc - RESET_PC;
        w        = imem[idx[7:0]];
        a        = mdl_regs[w[8:6]];
        b        = mdl_regs[w[2:0]];
        exp      = '0;
        exp.pc   = mpc;
        exp.insn = w;
        mpc      = mpc + 16'd1;
        case (w[15:12])
            OP_ADD: begin
                if (w[5]) begin
                    write_reg(exp, w[11:9], a + sext(w, 5));
                end else if (w[5:3] == 3'b010) begin
                    write_reg(exp, w[11:9], a - b);
                end else begin
                    write_reg(exp, w[11:9], a + b);
                end
            end
            OP_AND: write_reg(exp, w[11:9], w[5] ? (a & sext(w, 5)) : (a & b));
            OP_CONST: write_reg(exp, w[11:9], sext(w, 9));
            OP_LDR: begin
                exp.dmem_addr = a + sext(w, 6);
                exp.dmem_data = mdl_mem[exp.dmem_addr];
                write_reg(exp, w[11:9], exp.dmem_data);
            end
            OP_STR: begin
                exp.dmem_we   = 1'b1;
                exp.dmem_addr = a + sext(w, 6);
                exp.dmem_data = mdl_regs[w[11:9]];
                mdl_mem[exp.dmem_addr] = exp.dmem_data;
            end
            default: begin
                // br, taken when nzp meets the mask
                if ((mdl_nzp & w[11:9]) != 3'b000) begin
                    mpc = mpc + sext(w, 9);
                end
            end
        endcase
    endtask

    // samples on the falling edge, where the trace is settled
    task automatic wait_retire(input logic first, output retire_t got);
        int waited;
        waited = 0;
        @(negedge gwe);
        while (!retire_valid) begin
            if (first) begin
                check_equal("dmem_we before first retire", 16'(dmem_we), 16'h0);
            end
            if (waited >= RETIRE_TIMEOUT) begin
                fail_run("timeout: no instruction retired within 20 cycles");
            end
            waited++;
            @(negedge gwe);
        end
        got = retire;
    endtask

    task automatic compare_retire(input retire_t got, input retire_t exp);
        check_equal("pc", got.pc, exp.pc);
        check_equal("insn", got.insn, exp.insn);
        check_equal("regfile_we", 16'(got.regfile_we), 16'(exp.regfile_we));
        check_equal("nzp_we", 16'(got.nzp_we), 16'(exp.nzp_we));
        check_equal("dmem_we", 16'(got.dmem_we), 16'(exp.dmem_we));
        if (exp.regfile_we) begin
            check_equal("wsel", 16'(got.wsel), 16'(exp.wsel));
            check_equal("wdata", got.wdata, exp.wdata);
        end
        if (exp.nzp_we) begin
            check_equal("nzp", 16'(got.nzp), 16'(exp.nzp));
        end
        // loads and stores both carry address and data
        if (exp.dmem_we || exp.insn[15:12] == OP_LDR) begin
            check_equal("dmem_addr", got.dmem_addr, exp.dmem_addr);
            check_equal("dmem_data", got.dmem_data, exp.dmem_data);
            check_equal("port dmem_addr", port_addr_q, exp.dmem_addr);
        end else begin
            // address port idles at zero outside loads and stores
            check_equal("port dmem_addr", port_addr_q, 16'h0000);
        end
        check_equal("port dmem_we", 16'(port_we_q), 16'(exp.dmem_we));
        if (exp.dmem_we) begin
            check_equal("port dmem_wdata", port_wdata_q, exp.dmem_data);
        end
    endtask

    task automatic apply_reset();
        @(posedge gwe);
        #2 arst_n = 1'b0;
        build_program();
        repeat (7) @(posedge gwe);
        @(negedge gwe);
        check_equal("pc in reset", pc, RESET_PC);
        check_equal("retire_valid in reset", 16'(retire_valid), 16'h0);
        check_equal("dmem_we in reset", 16'(dmem_we), 16'h0);
        @(posedge gwe);
        #2 arst_n = 1'b1;
        @(negedge gwe);
        check_equal("pc after reset", pc, RESET_PC);
    endtask

    task automatic run_program(input int num);
        retire_t exp;
        retire_t got;
        word_t   mpc;
        int      count;
        mpc   = RESET_PC;
        count = 0;
        while (mpc < END_PC) begin
            model_step(mpc, exp);
            wait_retire(count == 0, got);
            compare_retire(got, exp);
            count++;
        end
        // next in line is the first trailing no-op, nothing squashed slips in
        wait_retire(1'b0, got);
        check_equal("pc after last instruction", got.pc, END_PC);
        $display("program %0d: %0d instructions retired", num, count);
    endtask

    initial begin
        arst_n = 1'b0;
        lfsr_q = 32'd97416;
        for (int p = 0; p < NUM_PROGS; p++) begin
            apply_reset();
            run_program(p);
        end
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== src.f ====
src/lc4_pkg.sv
src/lc4_pc_counter.sv
src/lc4_decoder.sv
src/lc4_regfile.sv
src/lc4_alu.sv
src/lc4_hazard_unit.sv
src/lc4_core.sv
verif/tb_lc4_core.sv

// ==== Bender.yml ====
package:
  name: lc4_core

dependencies: {}

sources:
  - src/lc4_pkg.sv
  - src/lc4_pc_counter.sv
  - src/lc4_decoder.sv
  - src/lc4_regfile.sv
  - src/lc4_alu.sv
  - src/lc4_hazard_unit.sv
  - src/lc4_core.sv
  - target: test
    files:
      - verif/tb_lc4_core.sv
